/* rtl/mips_pkg.sv */
package mips_pkg;

    // register index width, 32 registers
    localparam int reg_addr_w = 5;
    localparam int num_regs = 32;

    // instruction word and its fields
    localparam int instr_w = 32;
    localparam int opcode_w = 6;
    localparam int funct_w = 6;
    localparam int shamt_w = 5;
    localparam int imm_w = 16;

    // $v0 is tapped out of the register file
    localparam int v0_index = 2;

    // primary opcodes that are handled
    typedef enum logic [opcode_w-1:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [funct_w-1:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    // operations the ALU knows about
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

endpackage

/* rtl/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile #(
    parameter int data_w = 32
) (
    input  logic                            r_clk,
    input  logic                            reset,
    input  logic                            r_clk_enable,
    // write strobe qualified by the writeback handshake
    input  logic                            write_control,
    input  logic [mips_pkg::reg_addr_w-1:0] read_reg1,
    input  logic [mips_pkg::reg_addr_w-1:0] read_reg2,
    input  logic [mips_pkg::reg_addr_w-1:0] write_reg,
    input  logic [data_w-1:0]               write_data,
    output logic [data_w-1:0]               read_data1,
    output logic [data_w-1:0]               read_data2,
    output logic [data_w-1:0]               regfile_v0
);

    logic [data_w-1:0] registers [mips_pkg::num_regs];

    always_ff @(posedge r_clk) begin
        if (reset) begin
            // whole array back to zero
            for (int i = 0; i < mips_pkg::num_regs; i++) begin
                registers[i] <= '0;
            end
        end else if (r_clk_enable) begin
            // $zero is never stored
            if (write_control && write_reg != '0) begin
                registers[write_reg] <= write_data;
            end
        end
    end

    // async read with index 0 forced to zero
    assign read_data1 = (read_reg1 == '0) ? '0 : registers[read_reg1];
    assign read_data2 = (read_reg2 == '0) ? '0 : registers[read_reg2];

    // $v0 tap
    assign regfile_v0 = registers[mips_pkg::v0_index];

    // a retired write to $zero leaves the word behind port 1 at zero
    a_zero_reg_holds: assert property (
        @(posedge r_clk) disable iff (reset)
        (r_clk_enable && write_control && write_reg == '0)
            |=> (registers[0] == '0)
    ) else $error("register 0 storage changed after a write to it");

endmodule

/* rtl/mips_decoder.sv */
`timescale 1ns/1ps

module mips_decoder (
    input  logic [mips_pkg::instr_w-1:0]    instr,
    output logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    output logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    output logic [mips_pkg::reg_addr_w-1:0] dest_reg,
    output logic [31:0]                     imm_ext,
    output logic [mips_pkg::shamt_w-1:0]    shamt,
    output mips_pkg::alu_op_e               alu_op,
    output logic                            use_imm,
    output logic                            illegal
);

    logic [mips_pkg::opcode_w-1:0]   opcode;
    logic [mips_pkg::funct_w-1:0]    funct;
    logic [mips_pkg::reg_addr_w-1:0] rd_addr;
    logic [mips_pkg::imm_w-1:0]      imm;

    // fixed field positions of the MIPS-I word
    assign opcode  = instr[31:26];
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];
    assign shamt   = instr[10:6];
    assign funct   = instr[5:0];
    assign imm     = instr[15:0];

    always_comb begin
        // defaults, zero-extended immediate
        dest_reg = '0;
        alu_op   = mips_pkg::ALU_ADD;
        use_imm  = 1'b0;
        illegal  = 1'b0;
        imm_ext  = {16'b0, imm};
        case (mips_pkg::opcode_e'(opcode))
            mips_pkg::OP_SPECIAL: begin
                // R-type writes rd
                dest_reg = rd_addr;
                case (mips_pkg::funct_e'(funct))
                    mips_pkg::F_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::F_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::F_NOR:  alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::F_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::F_SLTU: alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::F_SLL:  alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::F_SRL:  alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::F_SRA:  alu_op = mips_pkg::ALU_SRA;
                    default:          illegal = 1'b1;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                dest_reg = rt_addr;
                use_imm  = 1'b1;
                imm_ext  = {{16{imm[15]}}, imm};
            end
            mips_pkg::OP_SLTI: begin
                dest_reg = rt_addr;
                use_imm  = 1'b1;
                alu_op   = mips_pkg::ALU_SLT;
                imm_ext  = {{16{imm[15]}}, imm};
            end
            mips_pkg::OP_SLTIU: begin
                // sign-extended, then compared unsigned
                dest_reg = rt_addr;
                use_imm  = 1'b1;
                alu_op   = mips_pkg::ALU_SLTU;
                imm_ext  = {{16{imm[15]}}, imm};
            end
            mips_pkg::OP_ANDI: begin
                dest_reg = rt_addr;
                use_imm  = 1'b1;
                alu_op   = mips_pkg::ALU_AND;
            end
            mips_pkg::OP_ORI: begin
                dest_reg = rt_addr;
                use_imm  = 1'b1;
                alu_op   = mips_pkg::ALU_OR;
            end
            mips_pkg::OP_XORI: begin
                dest_reg = rt_addr;
                use_imm  = 1'b1;
                alu_op   = mips_pkg::ALU_XOR;
            end
            mips_pkg::OP_LUI: begin
                // raw immediate, ALU moves it up
                dest_reg = rt_addr;
                use_imm  = 1'b1;
                alu_op   = mips_pkg::ALU_LUI;
            end
            default: illegal = 1'b1;
        endcase
        // unknown encodings write nothing
        if (illegal) begin
            dest_reg = '0;
            alu_op   = mips_pkg::ALU_ADD;
            use_imm  = 1'b0;
        end
    end

endmodule

/* rtl/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu #(
    parameter int data_w = 32
) (
    input  logic [data_w-1:0]            a,
    input  logic [data_w-1:0]            b,
    input  logic [data_w-1:0]            imm_ext,
    input  logic                         use_imm,
    input  logic [mips_pkg::shamt_w-1:0] shamt,
    input  mips_pkg::alu_op_e            alu_op,
    output logic [data_w-1:0]            result
);

    logic [data_w-1:0] op2;
    logic              lt_signed;
    logic              lt_unsigned;

    // second operand, register or immediate
    assign op2 = use_imm ? imm_ext : b;

    // compare flags
    assign lt_signed   = $signed(a) < $signed(op2);
    assign lt_unsigned = a < op2;

    always_comb begin
        result = '0;
        case (alu_op)
            mips_pkg::ALU_ADD: begin
                result = a + op2;
            end
            mips_pkg::ALU_SUB: begin
                result = a - op2;
            end
            mips_pkg::ALU_AND: begin
                result = a & op2;
            end
            mips_pkg::ALU_OR: begin
                result = a | op2;
            end
            mips_pkg::ALU_XOR: begin
                result = a ^ op2;
            end
            mips_pkg::ALU_NOR: begin
                result = ~(a | op2);
            end
            // set-less-than gives 0 or 1
            mips_pkg::ALU_SLT: begin
                result[0] = lt_signed;
            end
            mips_pkg::ALU_SLTU: begin
                result[0] = lt_unsigned;
            end
            // shifts act on rt, amount from shamt
            mips_pkg::ALU_SLL: begin
                result = op2 << shamt;
            end
            mips_pkg::ALU_SRL: begin
                result = op2 >> shamt;
            end
            mips_pkg::ALU_SRA: begin
                result = $signed(op2) >>> shamt;
            end
            // immediate into upper half
            mips_pkg::ALU_LUI: begin
                result = op2 << 16;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* rtl/mips_issue_ctrl.sv */
`timescale 1ns/1ps

module mips_issue_ctrl #(
    parameter int data_w = 32
) (
    input  logic                            r_clk,
    input  logic                            reset,
    input  logic                            r_clk_enable,
    // instruction stream in
    input  logic                            instr_valid,
    output logic                            instr_ready,
    input  logic [mips_pkg::instr_w-1:0]    instr,
    // held word for the decoder
    output logic [mips_pkg::instr_w-1:0]    cur_instr,
    // results of decoding/executing cur_instr
    input  logic [mips_pkg::reg_addr_w-1:0] dest_reg,
    input  logic [data_w-1:0]               alu_result,
    input  logic                            illegal,
    // writeback stream out
    output logic                            wb_valid,
    input  logic                            wb_ready,
    output logic                            wb_illegal,
    output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    output logic [data_w-1:0]               wb_data,
    // register file write port
    output logic                            write_control,
    output logic [mips_pkg::reg_addr_w-1:0] write_reg,
    output logic [data_w-1:0]               write_data
);

    typedef enum logic {
        ACCEPT,
        RETIRE
    } state_e;

    state_e state;
    logic   accept_xfer;
    logic   wb_xfer;

    // handshake edges with clock enable included
    assign accept_xfer = r_clk_enable && instr_valid && instr_ready;
    assign wb_xfer     = r_clk_enable && wb_valid && wb_ready;

    always_ff @(posedge r_clk) begin
        if (reset) begin
            state <= ACCEPT;
        end else if (accept_xfer) begin
            state <= RETIRE;
        end else if (wb_xfer) begin
            state <= ACCEPT;
        end
    end

    // word captured on accept
    always_ff @(posedge r_clk) begin
        if (accept_xfer) begin
            cur_instr <= instr;
        end
    end

    // one instruction in flight at a time
    assign instr_ready = (state == ACCEPT);
    assign wb_valid    = (state == RETIRE);

    // writeback is read straight off decoder and ALU
    assign wb_reg     = dest_reg;
    assign wb_data    = alu_result;
    assign wb_illegal = illegal;

    // commit on the writeback edge unless the word is illegal
    assign write_control = wb_xfer && !illegal;
    assign write_reg     = dest_reg;
    assign write_data    = alu_result;

    // payload holds while the consumer stalls
    a_wb_stable: assert property (
        @(posedge r_clk) disable iff (reset)
        (wb_valid && !(wb_ready && r_clk_enable)) |=> ($stable(wb_data) && $stable(wb_reg))
    ) else $error("writeback payload changed under back-pressure");

    // accepted word is held and offered for writeback
    a_one_in_flight: assert property (
        @(posedge r_clk) disable iff (reset)
        accept_xfer |=> (wb_valid && !instr_ready && cur_instr == $past(instr))
    ) else $error("accepted instruction not held for writeback");

endmodule

/* rtl/mips_exec_core.sv */
`timescale 1ns/1ps

module mips_exec_core #(
    parameter int data_w = 32
) (
    input  logic                            r_clk,
    input  logic                            reset,
    input  logic                            r_clk_enable,
    input  logic                            instr_valid,
    output logic                            instr_ready,
    input  logic [mips_pkg::instr_w-1:0]    instr,
    output logic                            wb_valid,
    input  logic                            wb_ready,
    output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    output logic [data_w-1:0]               wb_data,
    output logic                            wb_illegal,
    output logic [data_w-1:0]               register_v0
);

    logic [mips_pkg::instr_w-1:0]    cur_instr;
    logic [mips_pkg::reg_addr_w-1:0] rs_addr;
    logic [mips_pkg::reg_addr_w-1:0] rt_addr;
    logic [mips_pkg::reg_addr_w-1:0] dest_reg;
    logic [31:0]                     imm_ext;
    logic [mips_pkg::shamt_w-1:0]    shamt;
    mips_pkg::alu_op_e               alu_op;
    logic                            use_imm;
    logic                            illegal;
    logic [data_w-1:0]               read_data1;
    logic [data_w-1:0]               read_data2;
    logic [data_w-1:0]               alu_result;
    logic                            write_control;
    logic [mips_pkg::reg_addr_w-1:0] write_reg;
    logic [data_w-1:0]               write_data;

    // holds the word, owns both handshakes
    mips_issue_ctrl #(.data_w(data_w)) u_ctrl (
        .r_clk(r_clk), .reset(reset), .r_clk_enable(r_clk_enable),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
        .cur_instr(cur_instr), .dest_reg(dest_reg), .alu_result(alu_result),
        .illegal(illegal), .wb_valid(wb_valid), .wb_ready(wb_ready),
        .wb_illegal(wb_illegal), .wb_reg(wb_reg), .wb_data(wb_data),
        .write_control(write_control), .write_reg(write_reg), .write_data(write_data)
    );

    mips_decoder u_dec (
        .instr(cur_instr), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .dest_reg(dest_reg), .imm_ext(imm_ext), .shamt(shamt),
        .alu_op(alu_op), .use_imm(use_imm), .illegal(illegal)
    );

    mips_regfile #(.data_w(data_w)) u_rf (
        .r_clk(r_clk), .reset(reset), .r_clk_enable(r_clk_enable),
        .write_control(write_control), .read_reg1(rs_addr), .read_reg2(rt_addr),
        .write_reg(write_reg), .write_data(write_data),
        .read_data1(read_data1), .read_data2(read_data2), .regfile_v0(register_v0)
    );

    // immediate is 32 bits from the ISA, resized to the datapath
    mips_alu #(.data_w(data_w)) u_alu (
        .a(read_data1), .b(read_data2), .imm_ext(data_w'(imm_ext)),
        .use_imm(use_imm), .shamt(shamt), .alu_op(alu_op), .result(alu_result)
    );

endmodule

/* include/mips_ref_model.svh */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// golden model of one instruction, updates the model registers
function automatic void ref_execute(
    input  logic [31:0] instr,
    ref    logic [31:0] regs [mips_pkg::num_regs],
    output logic [4:0]  dest,
    output logic [31:0] value,
    output logic        illegal
);
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [4:0]  sh;
    rs_val  = regs[instr[25:21]];
    rt_val  = regs[instr[20:16]];
    sext    = {{16{instr[15]}}, instr[15:0]};
    zext    = {16'b0, instr[15:0]};
    sh      = instr[10:6];
    dest    = instr[20:16];
    value   = '0;
    illegal = 1'b0;
    case (mips_pkg::opcode_e'(instr[31:26]))
        mips_pkg::OP_SPECIAL: begin
            dest = instr[15:11];
            case (mips_pkg::funct_e'(instr[5:0]))
                mips_pkg::F_ADDU: value = rs_val + rt_val;
                mips_pkg::F_SUBU: value = rs_val - rt_val;
                mips_pkg::F_AND:  value = rs_val & rt_val;
                mips_pkg::F_OR:   value = rs_val | rt_val;
                mips_pkg::F_XOR:  value = rs_val ^ rt_val;
                mips_pkg::F_NOR:  value = ~(rs_val | rt_val);
                mips_pkg::F_SLT:  value = {31'b0, $signed(rs_val) < $signed(rt_val)};
                mips_pkg::F_SLTU: value = {31'b0, rs_val < rt_val};
                mips_pkg::F_SLL:  value = rt_val << sh;
                mips_pkg::F_SRL:  value = rt_val >> sh;
                mips_pkg::F_SRA:  value = $signed(rt_val) >>> sh;
                default:          illegal = 1'b1;
            endcase
        end
        mips_pkg::OP_ADDIU: value = rs_val + sext;
        mips_pkg::OP_SLTI:  value = {31'b0, $signed(rs_val) < $signed(sext)};
        mips_pkg::OP_SLTIU: value = {31'b0, rs_val < sext};
        mips_pkg::OP_ANDI:  value = rs_val & zext;
        mips_pkg::OP_ORI:   value = rs_val | zext;
        mips_pkg::OP_XORI:  value = rs_val ^ zext;
        mips_pkg::OP_LUI:   value = {instr[15:0], 16'b0};
        default:            illegal = 1'b1;
    endcase
    // illegal retires to $zero, nothing stored
    if (illegal) begin
        dest = '0;
    end else if (dest != '0) begin
        regs[dest] = value;
    end
endfunction

// expected value on the $v0 tap
function automatic logic [31:0] ref_v0(ref logic [31:0] regs [mips_pkg::num_regs]);
    return regs[mips_pkg::v0_index];
endfunction

`endif

/* test/mips_exec_tb.sv */
`timescale 1ns/1ps

module mips_exec_tb;

    localparam int data_w = 32;
    // cycles any single wait may take
    localparam int max_wait = 100;

    logic              r_clk;
    logic              reset;
    logic              r_clk_enable;
    logic              instr_valid;
    logic              instr_ready;
    logic [31:0]       instr;
    logic              wb_valid;
    logic              wb_ready;
    logic [4:0]        wb_reg;
    logic [data_w-1:0] wb_data;
    logic              wb_illegal;
    logic [data_w-1:0] register_v0;

    int seed;
    // enables random wb_ready and clock enable drops
    bit random_flow;

    // model register file running one instruction ahead of retirement
    logic [31:0] model_regs [mips_pkg::num_regs];
    logic [31:0] v0_expect;

    // expected writebacks with the oldest first
    string       exp_name [$];
    logic [4:0]  exp_dest [$];
    logic [31:0] exp_value [$];
    logic        exp_illegal [$];
    logic [31:0] exp_v0 [$];

    `include "mips_ref_model.svh"

    mips_exec_core #(.data_w(data_w)) uut (
        .r_clk(r_clk), .reset(reset), .r_clk_enable(r_clk_enable),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_reg(wb_reg),
        .wb_data(wb_data), .wb_illegal(wb_illegal), .register_v0(register_v0)
    );

    always #5 r_clk = ~r_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] r_type_word(input logic [5:0] funct, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // random index in 1..7 so operands get reused often
    function automatic logic [4:0] pick_reg();
        int r;
        r = $random(seed);
        return 5'(1 + ($unsigned(r) % 7));
    endfunction

    // queue the expected result, then hand the word over the stream
    task automatic issue_instr(input string name, input logic [31:0] word);
        logic [4:0]  dest;
        logic [31:0] value;
        logic        ill;
        int          waited;
        ref_execute(word, model_regs, dest, value, ill);
        exp_name.push_back(name);
        exp_dest.push_back(dest);
        exp_value.push_back(value);
        exp_illegal.push_back(ill);
        exp_v0.push_back(ref_v0(model_regs));
        @(posedge r_clk);
        instr_valid <= 1'b1;
        instr       <= word;
        // inputs settle by the falling edge and the transfer lands on the next rise
        waited = 0;
        @(negedge r_clk);
        while (!(r_clk_enable && instr_ready)) begin
            waited++;
            if (waited >= max_wait) begin
                abort_run("timeout: instr_ready never accepted the instruction");
            end
            @(negedge r_clk);
        end
        @(posedge r_clk);
        instr_valid <= 1'b0;
    endtask

    // full random words in r2..r7 via lui + ori
    task automatic seed_registers();
        logic [31:0] v;
        for (int r = 2; r < 8; r++) begin
            v = $random(seed);
            issue_instr($sformatf("lui r%0d", r), i_type_word(mips_pkg::OP_LUI, 5'd0, 5'(r),
                        v[31:16]));
            issue_instr($sformatf("ori r%0d", r), i_type_word(mips_pkg::OP_ORI, 5'(r), 5'(r),
                        v[15:0]));
        end
    endtask

    task automatic run_imm_ops();
        logic [5:0]  ops [7];
        logic [31:0] v;
        ops = '{mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI,
                mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_LUI};
        for (int k = 0; k < 7; k++) begin
            for (int n = 0; n < 4; n++) begin
                v = $random(seed);
                issue_instr($sformatf("imm op %h #%0d", ops[k], n),
                            i_type_word(ops[k], pick_reg(), pick_reg(), v[15:0]));
            end
        end
    endtask

    task automatic run_r_ops();
        logic [5:0]  functs [11];
        logic [31:0] v;
        functs = '{mips_pkg::F_ADDU, mips_pkg::F_SUBU, mips_pkg::F_AND, mips_pkg::F_OR,
                   mips_pkg::F_XOR, mips_pkg::F_NOR, mips_pkg::F_SLT, mips_pkg::F_SLTU,
                   mips_pkg::F_SLL, mips_pkg::F_SRL, mips_pkg::F_SRA};
        for (int k = 0; k < 11; k++) begin
            for (int n = 0; n < 4; n++) begin
                v = $random(seed);
                issue_instr($sformatf("r op %h #%0d", functs[k], n),
                            r_type_word(functs[k], pick_reg(), pick_reg(), pick_reg(), v[4:0]));
            end
        end
    endtask

    task automatic run_zero_and_v0();
        // writes to $zero retire and later reads still give zero
        issue_instr("addiu to r0", i_type_word(mips_pkg::OP_ADDIU, 5'd3, 5'd0, 16'h7abc));
        issue_instr("addu from r0", r_type_word(mips_pkg::F_ADDU, 5'd0, 5'd0, 5'd4, 5'd0));
        issue_instr("or r0 with r5", r_type_word(mips_pkg::F_OR, 5'd0, 5'd5, 5'd6, 5'd0));
        // $v0 tap checked by the monitor one cycle later
        issue_instr("ori to v0", i_type_word(mips_pkg::OP_ORI, 5'd0, 5'd2, 16'hbeef));
        issue_instr("lui to v0", i_type_word(mips_pkg::OP_LUI, 5'd0, 5'd2, 16'h1234));
        issue_instr("addu v0 read", r_type_word(mips_pkg::F_ADDU, 5'd2, 5'd0, 5'd7, 5'd0));
    endtask

    task automatic run_random_flow();
        int          kind;
        logic [31:0] v;
        random_flow <= 1'b1;
        for (int n = 0; n < 60; n++) begin
            kind = $unsigned($random(seed)) % 8;
            v = $random(seed);
            if (kind == 0) begin
                // lw and jr are outside the supported set
                if (v[31]) begin
                    issue_instr($sformatf("illegal lw #%0d", n), {6'h23, v[25:0]});
                end else begin
                    issue_instr($sformatf("illegal jr #%0d", n), {6'h00, v[25:6], 6'h08});
                end
            end else if (kind < 4) begin
                issue_instr($sformatf("flow addiu #%0d", n),
                            i_type_word(mips_pkg::OP_ADDIU, pick_reg(), pick_reg(), v[15:0]));
            end else begin
                issue_instr($sformatf("flow xor #%0d", n),
                            r_type_word(mips_pkg::F_XOR, pick_reg(), pick_reg(), pick_reg(),
                                        v[4:0]));
            end
        end
    endtask

    task automatic drain_writebacks();
        int waited;
        waited = 0;
        while (exp_dest.size() != 0) begin
            waited++;
            if (waited >= max_wait) begin
                abort_run("timeout: writeback stream never delivered the last results");
            end
            @(negedge r_clk);
        end
    endtask

    // random back-pressure and clock enable drops, otherwise both held high
    always @(posedge r_clk) begin
        if (random_flow) begin
            r_clk_enable <= ($random(seed) & 3) != 0;
            wb_ready     <= ($random(seed) & 1) == 1;
        end else begin
            r_clk_enable <= 1'b1;
            wb_ready     <= 1'b1;
        end
    end

    // writeback monitor sampling on the falling edge
    always @(negedge r_clk) begin
        string name;
        if (!reset) begin
            // tap reflects every write up to the last rising edge
            check_value("register_v0 tap", v0_expect, register_v0);
            if (r_clk_enable && wb_valid && wb_ready) begin
                if (exp_dest.size() == 0) begin
                    abort_run("writeback transfer arrived with no instruction outstanding");
                end else begin
                    name = exp_name.pop_front();
                    check_value({name, " wb_reg"}, exp_dest.pop_front(), wb_reg);
                    check_value({name, " wb_illegal"}, exp_illegal[0], wb_illegal);
                    // data of an illegal word carries no meaning
                    if (!exp_illegal.pop_front()) begin
                        check_value({name, " wb_data"}, exp_value[0], wb_data);
                    end
                    void'(exp_value.pop_front());
                    v0_expect = exp_v0.pop_front();
                end
            end
        end
    end

    initial begin
        seed         = 28;
        r_clk        = 1'b0;
        reset        = 1'b1;
        r_clk_enable = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        wb_ready     = 1'b1;
        random_flow  = 1'b0;
        v0_expect    = '0;
        for (int i = 0; i < mips_pkg::num_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge r_clk);
        reset <= 1'b0;
        @(negedge r_clk);
        check_value("v0 after reset", 32'h0, register_v0);
        // first word after reset returns the immediate
        issue_instr("ori after reset", i_type_word(mips_pkg::OP_ORI, 5'd0, 5'd1, 16'h5a5a));
        seed_registers();
        run_imm_ops();
        run_r_ops();
        run_zero_and_v0();
        run_random_flow();
        drain_writebacks();
        // quiet cycles where the monitor flags any stray transfer
        repeat (4) @(negedge r_clk);
        random_flow = 1'b0;
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* mips_exec.f */
+incdir+include
rtl/mips_pkg.sv
rtl/mips_regfile.sv
rtl/mips_decoder.sv
rtl/mips_alu.sv
rtl/mips_issue_ctrl.sv
rtl/mips_exec_core.sv
test/mips_exec_tb.sv

/* Bender.yml */
package:
  name: mips_exec

export_include_dirs:
  - include

sources:
  - files:
      - rtl/mips_pkg.sv
      - rtl/mips_regfile.sv
      - rtl/mips_decoder.sv
      - rtl/mips_alu.sv
      - rtl/mips_issue_ctrl.sv
      - rtl/mips_exec_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/mips_exec_tb.sv
